//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_da_core
RTL_TOP   ?= da_core_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
RTL_SRCS  ?= da_pkg.sv da_host_decoder.sv da_echo_fifo.sv da_slot_clock_ctl.sv \
             da_report_framer.sv da_core_top.sv
TB_SRCS   ?= tb_da_checker.sv tb_da_core.sv

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi; exit $$status

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- da_core_top.sv
////////////////////////////////////////////////////////////////////////////
// Core top level of the converter host command path. Connects the command
// decoder to the echo FIFO, the slot clock control and the report framer.
// Everything runs on cr_core; status bytes and board clocks arrive already
// sampled in that domain.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module da_core_top
    import da_pkg::*;
#(
    parameter int num_slots  = NUM_SLOTS,
    parameter int ECHO_DEPTH = 16
) (
    input  logic                    cr_core,
    input  logic                    reset_local,
    input  logic                    in_valid,
    input  host_word_t              in_data,
    output logic                    in_ready,
    output logic                    out_valid,
    output host_word_t              out_data,
    input  logic                    out_ready,
    input  logic                    clk0,
    input  logic                    clk1,
    input  logic [STATUS_WIDTH-1:0] dirchan,
    input  logic [STATUS_WIDTH-1:0] aovf,
    output logic [num_slots-1:0]    slot_clk,
    output logic [num_slots-1:0]    slot_reset
);

    logic                 echo_push;
    host_word_t           echo_data;
    logic                 echo_pop;
    host_word_t           echo_head;
    logic                 echo_head_valid;
    logic                 clksel_load;
    logic [num_slots-1:0] clksel_value;
    logic                 report_start;
    report_req_t          report_req;
    logic                 report_busy;

    // Decode stage
    da_host_decoder #(.num_slots(num_slots)) decoder_i (
        .cr_core(cr_core), .reset_local(reset_local),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .echo_push(echo_push), .echo_data(echo_data),
        .clksel_load(clksel_load), .clksel_value(clksel_value),
        .report_start(report_start), .report_req(report_req),
        .report_busy(report_busy)
    );

    // Execute stages
    da_echo_fifo #(.ECHO_DEPTH(ECHO_DEPTH)) echo_fifo_i (
        .cr_core(cr_core), .reset_local(reset_local),
        .push(echo_push), .push_data(echo_data), .pop(echo_pop),
        .head_data(echo_head), .head_valid(echo_head_valid)
    );

    da_slot_clock_ctl #(.num_slots(num_slots)) slot_clock_i (
        .cr_core(cr_core), .reset_local(reset_local),
        .clksel_load(clksel_load), .clksel_value(clksel_value),
        .clk0(clk0), .clk1(clk1),
        .slot_clk(slot_clk), .slot_reset(slot_reset)
    );

    // Result stage
    da_report_framer framer_i (
        .cr_core(cr_core), .reset_local(reset_local),
        .report_start(report_start), .report_req(report_req),
        .report_busy(report_busy),
        .echo_pop(echo_pop), .echo_data(echo_head), .echo_valid(echo_head_valid),
        .dirchan(dirchan), .aovf(aovf),
        .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready)
    );

endmodule

//--- da_echo_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Synchronous FIFO holding ECHO_SEND payload words until the framer streams
// them back. The head word is read combinationally and appears one cycle
// after it is pushed.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module da_echo_fifo
    import da_pkg::*;
#(
    parameter int ECHO_DEPTH = 16
) (
    input  logic       cr_core,
    input  logic       reset_local,
    input  logic       push,
    input  host_word_t push_data,
    input  logic       pop,
    output host_word_t head_data,
    output logic       head_valid
);

    localparam int AW = $clog2(ECHO_DEPTH);
    localparam int CW = $clog2(ECHO_DEPTH + 1);

    host_word_t     mem [ECHO_DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           do_push;
    logic           do_pop;

    // Pushes into a full store are dropped
    assign do_push    = push && (count != CW'(ECHO_DEPTH));
    assign do_pop     = pop && head_valid;
    assign head_valid = (count != '0);
    assign head_data  = mem[rd_ptr];

    always_ff @(posedge cr_core) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge cr_core) begin
        if (reset_local) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(ECHO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(ECHO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- da_host_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Host command decoder. Parses slot index, command code and command data
// from the host word stream, drives the echo FIFO and clock-select strobes
// and requests a report from the framer when a command needs a reply.
// Input flow control is held off while a report is in progress.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module da_host_decoder
    import da_pkg::*;
#(
    parameter int num_slots = NUM_SLOTS
) (
    input  logic                 cr_core,
    input  logic                 reset_local,
    input  logic                 in_valid,
    input  host_word_t           in_data,
    output logic                 in_ready,
    output logic                 echo_push,
    output host_word_t           echo_data,
    output logic                 clksel_load,
    output logic [num_slots-1:0] clksel_value,
    output logic                 report_start,
    output report_req_t          report_req,
    input  logic                 report_busy
);

    typedef enum logic [1:0] {ST_IDLE, ST_CODE, ST_DATA} state_t;

    state_t     state;
    cmd_code_t  cmd;
    logic [7:0] slot_idx;
    logic [3:0] echo_count;
    logic [4:0] word_count;
    logic       accept;

    assign accept = in_valid && in_ready;

    always_ff @(posedge cr_core) begin
        if (reset_local) begin
            state        <= ST_IDLE;
            in_ready     <= 1'b0;
            echo_push    <= 1'b0;
            clksel_load  <= 1'b0;
            report_start <= 1'b0;
        end else begin
            echo_push    <= 1'b0;
            clksel_load  <= 1'b0;
            report_start <= 1'b0;
            in_ready     <= !report_busy && !report_start;

            if (accept) begin
                case (state)
                    ST_IDLE: begin
                        slot_idx <= in_data[7:0];
                        state    <= ST_CODE;
                    end
                    ST_CODE: begin
                        cmd        <= cmd_code_t'(in_data[7:0]);
                        word_count <= '0;
                        case (cmd_code_t'(in_data[7:0]))
                            ECHO_SEND, SELECT_CLOCK: state <= ST_DATA;
                            DIRCHAN_READ: begin
                                report_start <= 1'b1;
                                report_req   <= '{slot: slot_idx, code: DIRCHAN_REPORT,
                                                  length: LENGTH_WIDTH'(1)};
                                in_ready     <= 1'b0;
                                state        <= ST_IDLE;
                            end
                            AOVF_READ: begin
                                report_start <= 1'b1;
                                report_req   <= '{slot: slot_idx, code: AOVF_REPORT,
                                                  length: LENGTH_WIDTH'(1)};
                                in_ready     <= 1'b0;
                                state        <= ST_IDLE;
                            end
                            // Drop an unknown code silently
                            default: state <= ST_IDLE;
                        endcase
                    end
                    default: begin
                        if (cmd == SELECT_CLOCK) begin
                            clksel_load  <= 1'b1;
                            clksel_value <= in_data[num_slots-1:0];
                            state        <= ST_IDLE;
                        end else if (word_count == 5'd0) begin
                            // Count word; only the low 4 bits matter
                            echo_count <= in_data[3:0];
                            word_count <= 5'd1;
                            if (in_data[3:0] == 4'd0) begin
                                report_start <= 1'b1;
                                report_req   <= '{slot: slot_idx, code: ECHO_REPORT,
                                                  length: '0};
                                in_ready     <= 1'b0;
                                state        <= ST_IDLE;
                            end
                        end else begin
                            echo_push  <= 1'b1;
                            echo_data  <= in_data;
                            word_count <= word_count + 5'd1;
                            if (word_count == {1'b0, echo_count}) begin
                                report_start <= 1'b1;
                                report_req   <= '{slot: slot_idx, code: ECHO_REPORT,
                                                  length: LENGTH_WIDTH'(echo_count)};
                                in_ready     <= 1'b0;
                                state        <= ST_IDLE;
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- da_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, command and report codes for the converter host path.
// Every RTL block of the core imports this package with a wildcard import
// in its module header.
////////////////////////////////////////////////////////////////////////////

package da_pkg;

    // Host word and slot count
    localparam int HOST_WIDTH   = 16;
    localparam int NUM_SLOTS    = 4;

    // Status bytes from the isolator board
    localparam int STATUS_WIDTH = 8;

    // Report length is sent as 8 high bits then 16 low bits
    localparam int LENGTH_WIDTH = 24;

    typedef logic [HOST_WIDTH-1:0] host_word_t;

    // Commands from the host
    typedef enum logic [7:0] {
        ECHO_SEND    = 8'h20,
        SELECT_CLOCK = 8'h30,
        DIRCHAN_READ = 8'h40,
        AOVF_READ    = 8'h41
    } cmd_code_t;

    // Reports back to the host
    typedef enum logic [7:0] {
        ECHO_REPORT    = 8'h21,
        DIRCHAN_REPORT = 8'h42,
        AOVF_REPORT    = 8'h43
    } report_code_t;

    // Handed from the decoder to the framer with report_start
    typedef struct packed {
        logic [7:0]              slot;
        report_code_t            code;
        logic [LENGTH_WIDTH-1:0] length;
    } report_req_t;

endpackage

//--- da_report_framer.sv
////////////////////////////////////////////////////////////////////////////
// Report framer for the host output. Sends slot, report code and length,
// then the payload from the echo FIFO or a status byte, then the 32-bit
// checksum of header and payload, high half first. The output word is
// registered and held while the host is not ready.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module da_report_framer
    import da_pkg::*;
(
    input  logic                    cr_core,
    input  logic                    reset_local,
    input  logic                    report_start,
    input  report_req_t             report_req,
    output logic                    report_busy,
    output logic                    echo_pop,
    input  host_word_t              echo_data,
    input  logic                    echo_valid,
    input  logic [STATUS_WIDTH-1:0] dirchan,
    input  logic [STATUS_WIDTH-1:0] aovf,
    output logic                    out_valid,
    output host_word_t              out_data,
    input  logic                    out_ready
);

    localparam int CNT_WIDTH = LENGTH_WIDTH + 1;

    report_req_t             req;
    logic [CNT_WIDTH-1:0]    word_cnt;
    logic [CNT_WIDTH-1:0]    pay_end;
    logic [CNT_WIDTH-1:0]    frame_end;
    logic [2*HOST_WIDTH-1:0] csum;
    host_word_t              next_word;
    logic                    advance;
    logic                    in_payload;
    logic                    echo_wait;
    logic                    load_word;

    // Word index runs over 4 header words, the payload and 2 checksum words
    assign pay_end    = CNT_WIDTH'(req.length) + CNT_WIDTH'(4);
    assign frame_end  = pay_end + CNT_WIDTH'(2);
    assign advance    = !out_valid || out_ready;
    assign in_payload = (word_cnt >= CNT_WIDTH'(4)) && (word_cnt < pay_end);
    assign echo_wait  = in_payload && (req.code == ECHO_REPORT) && !echo_valid;
    assign load_word  = report_busy && advance && !echo_wait && (word_cnt != frame_end);
    assign echo_pop   = load_word && in_payload && (req.code == ECHO_REPORT);

    always_comb begin
        if (word_cnt < CNT_WIDTH'(4)) begin
            case (word_cnt[1:0])
                2'd0:    next_word = HOST_WIDTH'(req.slot);
                2'd1:    next_word = HOST_WIDTH'(req.code);
                2'd2:    next_word = HOST_WIDTH'(req.length[LENGTH_WIDTH-1:16]);
                default: next_word = req.length[15:0];
            endcase
        end else if (in_payload) begin
            case (req.code)
                ECHO_REPORT:    next_word = echo_data;
                DIRCHAN_REPORT: next_word = HOST_WIDTH'(dirchan);
                default:        next_word = HOST_WIDTH'(aovf);
            endcase
        end else if (word_cnt == pay_end) begin
            next_word = csum[2*HOST_WIDTH-1:HOST_WIDTH];
        end else begin
            next_word = csum[HOST_WIDTH-1:0];
        end
    end

    always_ff @(posedge cr_core) begin
        if (reset_local) begin
            report_busy <= 1'b0;
            out_valid   <= 1'b0;
            word_cnt    <= '0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (report_start) begin
                report_busy <= 1'b1;
                word_cnt    <= '0;
            end else if (load_word) begin
                out_valid <= 1'b1;
                word_cnt  <= word_cnt + 1'b1;
            end else if (report_busy && advance && (word_cnt == frame_end)) begin
                // Last checksum word accepted by the host
                report_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge cr_core) begin
        if (report_start) begin
            req  <= report_req;
            csum <= '0;
        end else if (load_word) begin
            out_data <= next_word;
            if (word_cnt < pay_end) begin
                csum <= csum + (2*HOST_WIDTH)'(next_word);
            end
        end
    end

endmodule

//--- da_slot_clock_ctl.sv
////////////////////////////////////////////////////////////////////////////
// Per-slot converter clock selection. Holds the clock-select register,
// stops the clock of every slot that is switched over for one cycle and
// keeps that slot in reset until its new clock shows a rising edge.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module da_slot_clock_ctl
    import da_pkg::*;
#(
    parameter int num_slots = NUM_SLOTS
) (
    input  logic                 cr_core,
    input  logic                 reset_local,
    input  logic                 clksel_load,
    input  logic [num_slots-1:0] clksel_value,
    input  logic                 clk0,
    input  logic                 clk1,
    output logic [num_slots-1:0] slot_clk,
    output logic [num_slots-1:0] slot_reset
);

    logic [num_slots-1:0] clksel;
    logic [num_slots-1:0] clk_inhibit;
    logic [num_slots-1:0] release_mask;
    logic [num_slots-1:0] changed;
    logic                 clk0_last;
    logic                 clk1_last;
    logic                 clk0_rise;
    logic                 clk1_rise;

    assign clk0_rise = clk0 && !clk0_last;
    assign clk1_rise = clk1 && !clk1_last;
    assign changed   = clksel_load ? (clksel ^ clksel_value) : '0;

    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            // Release on the first edge of the chosen clock once unblocked
            release_mask[i] = slot_reset[i] && !clk_inhibit[i] &&
                              (clksel[i] ? clk1_rise : clk0_rise);
            slot_clk[i]     = !clk_inhibit[i] && (clksel[i] ? clk1 : clk0);
        end
    end

    always_ff @(posedge cr_core) begin
        clk0_last <= clk0;
        clk1_last <= clk1;
    end

    always_ff @(posedge cr_core) begin
        if (reset_local) begin
            clksel      <= '0;
            clk_inhibit <= '0;
            slot_reset  <= '1;
        end else begin
            clk_inhibit <= changed;
            slot_reset  <= (slot_reset & ~release_mask) | changed;
            if (clksel_load) begin
                clksel <= clksel_value;
            end
        end
    end

endmodule

//--- files.f
da_pkg.sv
da_host_decoder.sv
da_echo_fifo.sv
da_slot_clock_ctl.sv
da_report_framer.sv
da_core_top.sv
tb_da_checker.sv
tb_da_core.sv

//--- tb_da_checker.sv
////////////////////////////////////////////////////////////////////////////
// Testbench checker for the converter core. Compares every word accepted
// on the host output with the words queued by the testbench model, checks
// that a stalled word is held, and watches the slot clocks and resets.
// The testbench fills the queue and the clock selection through tasks.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_da_checker
    import da_pkg::*;
#(
    parameter int num_slots = NUM_SLOTS
) (
    input logic                 cr_core,
    input logic                 reset_local,
    input logic                 out_valid,
    input host_word_t           out_data,
    input logic                 out_ready,
    input logic                 clk0,
    input logic                 clk1,
    input logic [num_slots-1:0] slot_clk,
    input logic [num_slots-1:0] slot_reset
);

    host_word_t           exp_q[$];
    logic [num_slots-1:0] sel;
    logic [num_slots-1:0] prev_reset;
    logic                 held;
    host_word_t           held_data;
    host_word_t           exp_word;
    logic                 sel_clk;
    int                   word_index;
    int                   error_count;

    initial begin
        sel         = '0;
        prev_reset  = '0;
        held        = 1'b0;
        held_data   = '0;
        word_index  = 0;
        error_count = 0;
    end

    task automatic note_error(input string msg);
        $display("error %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic expect_word(input host_word_t w);
        exp_q.push_back(w);
    endtask

    task automatic set_select(input logic [num_slots-1:0] value);
        sel = value;
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            note_error($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    // Called one cycle after the select word was taken
    task automatic check_switch(input logic [num_slots-1:0] changed);
        check_value("slot_reset after clock select", 32'(slot_reset), 32'(changed));
        check_value("slot_clk of switched slots", 32'(slot_clk & changed), 32'd0);
    endtask

    // Outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge cr_core) begin
        if (!reset_local) begin
            if (held && (out_valid !== 1'b1 || out_data !== held_data)) begin
                note_error($sformatf("stalled word %h was not held", held_data));
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    note_error($sformatf("output word %h arrived with no report expected",
                                         out_data));
                end else begin
                    exp_word = exp_q.pop_front();
                    if (out_data !== exp_word) begin
                        note_error($sformatf("output word %0d is %h, expected %h",
                                             word_index, out_data, exp_word));
                    end
                end
                word_index++;
            end
            held      = out_valid && !out_ready;
            held_data = out_data;

            for (int i = 0; i < num_slots; i++) begin
                sel_clk = sel[i] ? clk1 : clk0;
                if (slot_reset[i] === 1'b0 && slot_clk[i] !== sel_clk) begin
                    note_error($sformatf("slot_clk[%0d] does not follow its clock", i));
                end
                // A release must come from a rising edge, so the clock is still high
                if (prev_reset[i] === 1'b1 && slot_reset[i] === 1'b0 && sel_clk !== 1'b1) begin
                    note_error($sformatf("slot_reset[%0d] fell with its clock low", i));
                end
            end
        end
        prev_reset = slot_reset;
    end

endmodule

//--- tb_da_core.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the converter core. Sends random ECHO_SEND, status read,
// SELECT_CLOCK and unknown commands, stalls the host output at random and
// toggles the board clocks. A model queues every expected report word in
// the checker, which compares the DUT output and watches the slots.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_da_core
    import da_pkg::*;
;

    localparam logic [31:0] SEED    = 32'h36b545bb;
    localparam int          TIMEOUT = 400;

    logic                    cr_core;
    logic                    reset_local;
    logic                    in_valid;
    host_word_t              in_data;
    logic                    in_ready;
    logic                    out_valid;
    host_word_t              out_data;
    logic                    out_ready;
    logic                    clk0;
    logic                    clk1;
    logic [STATUS_WIDTH-1:0] dirchan;
    logic [STATUS_WIDTH-1:0] aovf;
    logic [NUM_SLOTS-1:0]    slot_clk;
    logic [NUM_SLOTS-1:0]    slot_reset;

    logic [31:0]          stim_state;
    logic [31:0]          board_state;
    logic [NUM_SLOTS-1:0] exp_sel;
    host_word_t           model_payload[$];
    int                   tests_run;
    int                   tests_failed;
    int                   errors_at_start;

    da_core_top #(.num_slots(NUM_SLOTS), .ECHO_DEPTH(16)) dut_i (
        .cr_core(cr_core), .reset_local(reset_local),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
        .clk0(clk0), .clk1(clk1), .dirchan(dirchan), .aovf(aovf),
        .slot_clk(slot_clk), .slot_reset(slot_reset)
    );

    tb_da_checker #(.num_slots(NUM_SLOTS)) checker_i (
        .cr_core(cr_core), .reset_local(reset_local),
        .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
        .clk0(clk0), .clk1(clk1), .slot_clk(slot_clk), .slot_reset(slot_reset)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    initial begin
        cr_core = 1'b0;
        forever #50 cr_core = ~cr_core;
    end

    // Board clocks and output stalls come from a stream of their own
    initial begin : board_drive
        int cnt0;
        int cnt1;
        clk0        = 1'b0;
        clk1        = 1'b0;
        out_ready   = 1'b1;
        board_state = ~SEED;
        cnt0        = 2;
        cnt1        = 3;
        forever begin
            @(posedge cr_core);
            #1;
            board_state = xorshift32(board_state);
            out_ready   = (board_state[1:0] != 2'd0);
            if (cnt0 == 0) begin
                clk0 = ~clk0;
                cnt0 = 1 + int'(board_state[5:4]);
            end else begin
                cnt0--;
            end
            if (cnt1 == 0) begin
                clk1 = ~clk1;
                cnt1 = 1 + int'(board_state[9:8]);
            end else begin
                cnt1--;
            end
        end
    end

    task automatic give_up(input string what);
        $display("timeout: %s", what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic send_word(input host_word_t w);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_data  = w;
        while (!in_ready) begin
            if (waited == TIMEOUT) begin
                give_up("host input never became ready");
            end
            @(posedge cr_core);
            #1;
            waited++;
        end
        @(posedge cr_core);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_report_done();
        int waited;
        waited = 0;
        while (checker_i.pending() != 0) begin
            if (waited == TIMEOUT) begin
                give_up("report words did not all arrive");
            end
            @(posedge cr_core);
            #1;
            waited++;
        end
    endtask

    task automatic wait_released();
        int waited;
        waited = 0;
        while (slot_reset != '0) begin
            if (waited == TIMEOUT) begin
                give_up("slot reset was never released");
            end
            @(posedge cr_core);
            #1;
            waited++;
        end
    endtask

    // Frame is the header and payload followed by their 32-bit sum with the high half first
    task automatic expect_report(input logic [7:0] slot, input logic [7:0] code);
        host_word_t  frame[$];
        logic [23:0] len;
        logic [31:0] sum;
        len = 24'(model_payload.size());
        sum = '0;
        frame.push_back({8'h00, slot});
        frame.push_back({8'h00, code});
        frame.push_back({8'h00, len[23:16]});
        frame.push_back(len[15:0]);
        foreach (model_payload[i]) begin
            frame.push_back(model_payload[i]);
        end
        foreach (frame[i]) begin
            sum = sum + 32'(frame[i]);
        end
        frame.push_back(sum[31:16]);
        frame.push_back(sum[15:0]);
        foreach (frame[i]) begin
            checker_i.expect_word(frame[i]);
        end
    endtask

    // A negative count picks one at random
    task automatic send_echo(input int force_n);
        logic [31:0] r;
        host_word_t  count_word;
        int          n;
        r          = next_rand();
        count_word = r[31:16];
        if (force_n >= 0) begin
            count_word[3:0] = 4'(force_n);
        end
        n = int'(count_word[3:0]);
        model_payload = {};
        for (int i = 0; i < n; i++) begin
            model_payload.push_back(host_word_t'(next_rand()));
        end
        expect_report(r[7:0], ECHO_REPORT);
        send_word({8'h00, r[7:0]});
        send_word({8'h00, ECHO_SEND});
        send_word(count_word);
        foreach (model_payload[i]) begin
            send_word(model_payload[i]);
        end
        wait_report_done();
    endtask

    task automatic read_status(input logic read_aovf);
        logic [31:0] r;
        r       = next_rand();
        dirchan = r[15:8];
        aovf    = r[23:16];
        model_payload = {};
        model_payload.push_back({8'h00, read_aovf ? aovf : dirchan});
        expect_report(r[7:0], read_aovf ? AOVF_REPORT : DIRCHAN_REPORT);
        send_word({8'h00, r[7:0]});
        send_word({8'h00, read_aovf ? AOVF_READ : DIRCHAN_READ});
        wait_report_done();
    endtask

    task automatic switch_clock_select(input logic flip_all);
        logic [31:0]          r;
        host_word_t           sel_word;
        logic [NUM_SLOTS-1:0] new_sel;
        r        = next_rand();
        sel_word = r[31:16];
        if (flip_all) begin
            sel_word[NUM_SLOTS-1:0] = ~exp_sel;
        end
        new_sel = sel_word[NUM_SLOTS-1:0];
        send_word({8'h00, r[7:0]});
        send_word({8'h00, SELECT_CLOCK});
        send_word(sel_word);
        @(posedge cr_core);
        #1;
        checker_i.check_switch(new_sel ^ exp_sel);
        exp_sel = new_sel;
        checker_i.set_select(new_sel);
        wait_released();
    endtask

    task automatic send_unknown_code();
        logic [31:0] r;
        r = next_rand();
        send_word({8'h00, r[7:0]});
        send_word({8'h00, 1'b1, r[14:8]});
        // A report would start within 3 cycles
        for (int i = 0; i < 8; i++) begin
            checker_i.check_value("out_valid after unknown code", 32'(out_valid), 32'd0);
            @(posedge cr_core);
            #1;
        end
    endtask

    task automatic start_test();
        errors_at_start = checker_i.error_count;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = checker_i.error_count - errors_at_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    initial begin
        stim_state   = SEED;
        reset_local  = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        dirchan      = '0;
        aovf         = '0;
        exp_sel      = '0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge cr_core);
        #1;
        reset_local = 1'b0;

        start_test();
        checker_i.check_value("in_ready after reset", 32'(in_ready), 32'd0);
        checker_i.check_value("out_valid after reset", 32'(out_valid), 32'd0);
        checker_i.check_value("report_busy after reset", 32'(dut_i.report_busy), 32'd0);
        checker_i.check_value("clksel after reset", 32'(dut_i.slot_clock_i.clksel), 32'd0);
        checker_i.check_value("slot_reset after reset", 32'(slot_reset), 32'hf);
        wait_released();
        finish_test("reset_release");

        start_test();
        send_echo(0);
        send_echo(15);
        for (int i = 0; i < 6; i++) begin
            send_echo(-1);
        end
        finish_test("echo_send");

        start_test();
        for (int i = 0; i < 3; i++) begin
            read_status(1'b0);
            read_status(1'b1);
        end
        finish_test("status_read");

        start_test();
        switch_clock_select(1'b1);
        for (int i = 0; i < 4; i++) begin
            switch_clock_select(1'b0);
        end
        finish_test("select_clock");

        start_test();
        send_unknown_code();
        read_status(1'b0);
        send_unknown_code();
        send_echo(-1);
        finish_test("unknown_code");

        start_test();
        for (int i = 0; i < 24; i++) begin
            case (next_rand() % 32'd5)
                32'd0:   send_echo(-1);
                32'd1:   read_status(1'b0);
                32'd2:   read_status(1'b1);
                32'd3:   switch_clock_select(1'b0);
                default: send_unknown_code();
            endcase
        end
        finish_test("random_mix");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, checker_i.error_count);
        if (tests_failed == 0 && checker_i.error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
